//--- Makefile
# Verilator flow for the offload interconnect testbench

VERILATOR  ?= verilator
TOP        ?= tb_offload_cc
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
hw/offload_pkg.sv
hw/spill_reg.sv
hw/offload_router.sv
hw/int_unit.sv
hw/offload_cc.sv
testbench/offload_cc_assert.sv
testbench/tb_offload_cc.sv

//--- hw/int_unit.sv
/* Two-stage integer unit behind a valid/ready port. Stage one decodes,
   stage two registers the result; unknown op codes return zero with error */
`default_nettype none

module int_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  output logic               ready_o,
  input  offload_pkg::id_t   id_i,
  input  offload_pkg::op_t   op_i,
  input  offload_pkg::data_t arga_i,
  input  offload_pkg::data_t argb_i,
  output logic               valid_o,
  input  logic               ready_i,
  output offload_pkg::data_t data_o,
  output offload_pkg::id_t   id_o,
  output logic               error_o
);

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluMul,
    AluAnd,
    AluXor,
    AluIllegal
  } alu_op_e;

  alu_op_e            op_dec, s1_alu_q;
  logic               s1_valid_q, s2_valid_q;
  offload_pkg::id_t   s1_id_q, s2_id_q;
  offload_pkg::data_t s1_arga_q, s1_argb_q, s2_data_q;
  logic               s2_error_q;
  offload_pkg::data_t result;
  logic               result_error;
  logic               s2_ready, s1_load, s2_load;

  // --------------------
  // Pipeline control
  // --------------------
  // A stalled stage two holds stage one in place
  assign s2_ready = ~s2_valid_q | ready_i;
  assign ready_o  = ~s1_valid_q | s2_ready;
  assign s1_load  = valid_i & ready_o;
  assign s2_load  = s1_valid_q & s2_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (ready_o) begin
        s1_valid_q <= valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // --------------------
  // Stage one
  // --------------------
  always_comb begin
    case (op_i)
      offload_pkg::OpAdd: op_dec = AluAdd;
      offload_pkg::OpSub: op_dec = AluSub;
      offload_pkg::OpMul: op_dec = AluMul;
      offload_pkg::OpAnd: op_dec = AluAnd;
      offload_pkg::OpXor: op_dec = AluXor;
      default:            op_dec = AluIllegal;
    endcase
  end

  // --------------------
  // Stage two
  // --------------------
  always_comb begin
    result_error = 1'b0;
    case (s1_alu_q)
      AluAdd:  result = s1_arga_q + s1_argb_q;
      AluSub:  result = s1_arga_q - s1_argb_q;
      // Low word of the product
      AluMul:  result = s1_arga_q * s1_argb_q;
      AluAnd:  result = s1_arga_q & s1_argb_q;
      AluXor:  result = s1_arga_q ^ s1_argb_q;
      default: begin
        result       = '0;
        result_error = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s1_load) begin
      s1_alu_q  <= op_dec;
      s1_id_q   <= id_i;
      s1_arga_q <= arga_i;
      s1_argb_q <= argb_i;
    end
    if (s2_load) begin
      s2_data_q  <= result;
      s2_error_q <= result_error;
      s2_id_q    <= s1_id_q;
    end
  end

  assign valid_o = s2_valid_q;
  assign data_o  = s2_data_q;
  assign id_o    = s2_id_q;
  assign error_o = s2_error_q;

endmodule

`default_nettype wire

//--- hw/offload_cc.sv
/* Top level of the offload interconnect. Core requests pass an optional cut,
   go to the integer unit or the shared port, and responses return through a cut */
`default_nettype none

module offload_cc #(
  parameter bit RegisterReq  = 1'b1,
  parameter bit RegisterResp = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Core request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  offload_pkg::addr_t req_addr_i,
  input  offload_pkg::id_t   req_id_i,
  input  offload_pkg::op_t   req_op_i,
  input  offload_pkg::data_t req_arga_i,
  input  offload_pkg::data_t req_argb_i,
  // Core response
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output offload_pkg::data_t resp_data_o,
  output offload_pkg::id_t   resp_id_o,
  output logic               resp_error_o,
  // Shared unit request
  output logic               sh_req_valid_o,
  input  logic               sh_req_ready_i,
  output offload_pkg::id_t   sh_req_id_o,
  output offload_pkg::op_t   sh_req_op_o,
  output offload_pkg::data_t sh_req_arga_o,
  output offload_pkg::data_t sh_req_argb_o,
  // Shared unit response
  input  logic               sh_resp_valid_i,
  output logic               sh_resp_ready_o,
  input  offload_pkg::data_t sh_resp_data_i,
  input  offload_pkg::id_t   sh_resp_id_i,
  input  logic               sh_resp_error_i
);

  localparam int unsigned ReqWidth = $bits(offload_pkg::addr_t) + $bits(offload_pkg::id_t)
                                   + $bits(offload_pkg::op_t) + 2 * $bits(offload_pkg::data_t);
  localparam int unsigned RespWidth = $bits(offload_pkg::data_t) + $bits(offload_pkg::id_t) + 1;

  // Request after the cut
  logic               req_q_valid, req_q_ready;
  offload_pkg::addr_t req_q_addr;
  offload_pkg::id_t   req_q_id;
  offload_pkg::op_t   req_q_op;
  offload_pkg::data_t req_q_arga, req_q_argb;

  logic int_req_valid, int_req_ready;

  // Integer unit response
  logic               int_resp_valid, int_resp_ready, int_resp_error;
  offload_pkg::data_t int_resp_data;
  offload_pkg::id_t   int_resp_id;

  // Merged response ahead of the cut
  logic               arb_valid, arb_ready, arb_error;
  offload_pkg::data_t arb_data;
  offload_pkg::id_t   arb_id;

  // --------------------
  // Request path
  // --------------------
  spill_reg #(
    .Bypass ( !RegisterReq ),
    .Width  ( ReqWidth     )
  ) i_req_cut (
    .clk_i   ( clk_i                                                  ),
    .rst_ni  ( rst_ni                                                 ),
    .valid_i ( req_valid_i                                            ),
    .ready_o ( req_ready_o                                            ),
    .data_i  ( {req_addr_i, req_id_i, req_op_i, req_arga_i, req_argb_i} ),
    .valid_o ( req_q_valid                                            ),
    .ready_i ( req_q_ready                                            ),
    .data_o  ( {req_q_addr, req_q_id, req_q_op, req_q_arga, req_q_argb} )
  );

  offload_router i_router (
    .clk_i            ( clk_i           ),
    .rst_ni           ( rst_ni          ),
    .req_valid_i      ( req_q_valid     ),
    .req_addr_i       ( req_q_addr      ),
    .req_ready_o      ( req_q_ready     ),
    .int_req_valid_o  ( int_req_valid   ),
    .int_req_ready_i  ( int_req_ready   ),
    .sh_req_valid_o   ( sh_req_valid_o  ),
    .sh_req_ready_i   ( sh_req_ready_i  ),
    .int_resp_valid_i ( int_resp_valid  ),
    .int_resp_data_i  ( int_resp_data   ),
    .int_resp_id_i    ( int_resp_id     ),
    .int_resp_error_i ( int_resp_error  ),
    .int_resp_ready_o ( int_resp_ready  ),
    .sh_resp_valid_i  ( sh_resp_valid_i ),
    .sh_resp_data_i   ( sh_resp_data_i  ),
    .sh_resp_id_i     ( sh_resp_id_i    ),
    .sh_resp_error_i  ( sh_resp_error_i ),
    .sh_resp_ready_o  ( sh_resp_ready_o ),
    .out_valid_o      ( arb_valid       ),
    .out_data_o       ( arb_data        ),
    .out_id_o         ( arb_id          ),
    .out_error_o      ( arb_error       ),
    .out_ready_i      ( arb_ready       )
  );

  int_unit i_int_unit (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .valid_i ( int_req_valid  ),
    .ready_o ( int_req_ready  ),
    .id_i    ( req_q_id       ),
    .op_i    ( req_q_op       ),
    .arga_i  ( req_q_arga     ),
    .argb_i  ( req_q_argb     ),
    .valid_o ( int_resp_valid ),
    .ready_i ( int_resp_ready ),
    .data_o  ( int_resp_data  ),
    .id_o    ( int_resp_id    ),
    .error_o ( int_resp_error )
  );

  // Shared unit sees the payload of every routed request
  assign sh_req_id_o   = req_q_id;
  assign sh_req_op_o   = req_q_op;
  assign sh_req_arga_o = req_q_arga;
  assign sh_req_argb_o = req_q_argb;

  // --------------------
  // Response path
  // --------------------
  spill_reg #(
    .Bypass ( !RegisterResp ),
    .Width  ( RespWidth     )
  ) i_resp_cut (
    .clk_i   ( clk_i                                  ),
    .rst_ni  ( rst_ni                                 ),
    .valid_i ( arb_valid                              ),
    .ready_o ( arb_ready                              ),
    .data_i  ( {arb_data, arb_id, arb_error}          ),
    .valid_o ( resp_valid_o                           ),
    .ready_i ( resp_ready_i                           ),
    .data_o  ( {resp_data_o, resp_id_o, resp_error_o} )
  );

endmodule

`default_nettype wire

//--- hw/offload_pkg.sv
/* Widths, operation codes and router target indices of the offload interconnect.
   Shared by the RTL and the testbench through scoped names */
`default_nettype none

package offload_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 5;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned OpWidth   = 4;

  // Request address with bit 0 as target select
  typedef logic [AddrWidth-1:0] addr_t;
  // Tag returned unchanged with the response
  typedef logic [IdWidth-1:0]   id_t;
  // Operand and result word
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [OpWidth-1:0]   op_t;

  // --------------------
  // Operation codes
  // --------------------
  // Codes above OpXor are illegal in the integer unit
  localparam op_t OpAdd = 4'd0;
  localparam op_t OpSub = 4'd1;
  localparam op_t OpMul = 4'd2;
  localparam op_t OpAnd = 4'd3;
  localparam op_t OpXor = 4'd4;

  // --------------------
  // Router targets
  // --------------------
  localparam int unsigned NumTargets = 2;
  typedef logic [$clog2(NumTargets)-1:0] target_t;
  localparam target_t TargetInt    = 1'b0;
  localparam target_t TargetShared = 1'b1;

endpackage

`default_nettype wire

//--- hw/offload_router.sv
/* Steers offload requests to the integer unit or the shared port by address
   bit 0, and merges both response streams with a round-robin arbiter */
`default_nettype none

module offload_router (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Request side
  input  logic                req_valid_i,
  input  offload_pkg::addr_t  req_addr_i,
  output logic                req_ready_o,
  output logic                int_req_valid_o,
  input  logic                int_req_ready_i,
  output logic                sh_req_valid_o,
  input  logic                sh_req_ready_i,
  // Response sources
  input  logic                int_resp_valid_i,
  input  offload_pkg::data_t  int_resp_data_i,
  input  offload_pkg::id_t    int_resp_id_i,
  input  logic                int_resp_error_i,
  output logic                int_resp_ready_o,
  input  logic                sh_resp_valid_i,
  input  offload_pkg::data_t  sh_resp_data_i,
  input  offload_pkg::id_t    sh_resp_id_i,
  input  logic                sh_resp_error_i,
  output logic                sh_resp_ready_o,
  // Merged response
  output logic                out_valid_o,
  output offload_pkg::data_t  out_data_o,
  output offload_pkg::id_t    out_id_o,
  output logic                out_error_o,
  input  logic                out_ready_i
);

  // --------------------
  // Request demux
  // --------------------
  offload_pkg::target_t                sel;
  logic [offload_pkg::NumTargets-1:0] req_valid_vec;
  logic [offload_pkg::NumTargets-1:0] req_ready_vec;

  assign sel = req_addr_i[0];

  always_comb begin
    req_valid_vec      = '0;
    req_valid_vec[sel] = req_valid_i;
  end

  assign int_req_valid_o = req_valid_vec[offload_pkg::TargetInt];
  assign sh_req_valid_o  = req_valid_vec[offload_pkg::TargetShared];

  assign req_ready_vec[offload_pkg::TargetInt]    = int_req_ready_i;
  assign req_ready_vec[offload_pkg::TargetShared] = sh_req_ready_i;
  assign req_ready_o = req_ready_vec[sel];

  // --------------------
  // Response arbiter
  // --------------------
  logic [offload_pkg::NumTargets-1:0] resp_valid_vec;
  logic [offload_pkg::NumTargets-1:0] resp_ready_vec;
  logic [offload_pkg::NumTargets-1:0] resp_error_vec;
  offload_pkg::data_t                  resp_data_vec [offload_pkg::NumTargets];
  offload_pkg::id_t                    resp_id_vec   [offload_pkg::NumTargets];

  offload_pkg::target_t rr_q, gnt_q, gnt;
  logic                 lock_q;
  logic                 out_hs;

  assign resp_valid_vec[offload_pkg::TargetInt]    = int_resp_valid_i;
  assign resp_valid_vec[offload_pkg::TargetShared] = sh_resp_valid_i;
  assign resp_error_vec[offload_pkg::TargetInt]    = int_resp_error_i;
  assign resp_error_vec[offload_pkg::TargetShared] = sh_resp_error_i;
  assign resp_data_vec[offload_pkg::TargetInt]     = int_resp_data_i;
  assign resp_data_vec[offload_pkg::TargetShared]  = sh_resp_data_i;
  assign resp_id_vec[offload_pkg::TargetInt]       = int_resp_id_i;
  assign resp_id_vec[offload_pkg::TargetShared]    = sh_resp_id_i;

  // Locked grant keeps the output payload stable while stalled
  always_comb begin
    if (lock_q) begin
      gnt = gnt_q;
    end else if (resp_valid_vec[rr_q]) begin
      gnt = rr_q;
    end else begin
      gnt = offload_pkg::target_t'(rr_q + 1'b1);
    end
  end

  assign out_valid_o = resp_valid_vec[gnt];
  assign out_data_o  = resp_data_vec[gnt];
  assign out_id_o    = resp_id_vec[gnt];
  assign out_error_o = resp_error_vec[gnt];
  assign out_hs      = out_valid_o & out_ready_i;

  always_comb begin
    resp_ready_vec      = '0;
    resp_ready_vec[gnt] = out_hs;
  end

  assign int_resp_ready_o = resp_ready_vec[offload_pkg::TargetInt];
  assign sh_resp_ready_o  = resp_ready_vec[offload_pkg::TargetShared];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= offload_pkg::TargetInt;
      gnt_q  <= offload_pkg::TargetInt;
      lock_q <= 1'b0;
    end else if (out_hs) begin
      // Other source first next time
      rr_q   <= offload_pkg::target_t'(gnt + 1'b1);
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      gnt_q  <= gnt;
      lock_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/spill_reg.sv
/* Two-entry valid/ready pipeline cut for a packed payload vector.
   Set Bypass to replace the cut by a straight combinational connection */
`default_nettype none

module spill_reg #(
  parameter bit          Bypass = 1'b0,
  parameter int unsigned Width  = 32
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_cut
    // Slot A takes new input, slot B catches A when the output stalls
    logic             a_full_q, b_full_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             active_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    // Input held off until the first cycle after reset
    assign ready_o = active_q & (~a_full_q | ~b_full_q);

    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    // B always holds the older item
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        active_q <= 1'b0;
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        active_q <= 1'b1;
        if (a_fill) begin
          a_full_q <= 1'b1;
        end else if (a_drain) begin
          a_full_q <= 1'b0;
        end
        if (b_fill) begin
          b_full_q <= 1'b1;
        end else if (b_drain) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/offload_cc_assert.sv
/* Concurrent handshake checks on the offload_cc ports.
   Attached to every offload_cc instance by the bind at the end of this file */
`default_nettype none

module offload_cc_assert #(
  parameter int unsigned ReqBits  = $bits(offload_pkg::addr_t) + $bits(offload_pkg::id_t)
                                  + $bits(offload_pkg::op_t) + 2 * $bits(offload_pkg::data_t),
  parameter int unsigned RespBits = $bits(offload_pkg::data_t) + $bits(offload_pkg::id_t) + 1
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_valid_i,
  input logic                req_ready_i,
  input offload_pkg::addr_t  req_addr_i,
  input offload_pkg::id_t    req_id_i,
  input logic [ReqBits-1:0]  req_payload_i,
  input logic                resp_valid_i,
  input logic                resp_ready_i,
  input logic [RespBits-1:0] resp_payload_i,
  input logic                sh_req_valid_i,
  input offload_pkg::id_t    sh_req_id_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IdCount = 2 ** $bits(offload_pkg::id_t);

  // Target chosen for each id when the core handed it over
  logic [IdCount-1:0] to_shared_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      to_shared_q <= '0;
    end else if (req_valid_i && req_ready_i) begin
      to_shared_q[req_id_i] <= (req_addr_i[0] == offload_pkg::TargetShared);
    end
  end

  // Stalled transfers keep valid and payload
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_payload_i))
    else $error("request payload changed while waiting for ready");

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_payload_i))
    else $error("response payload changed while waiting for ready");

  // Shared port only carries ids that entered with an odd address
  sh_route: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sh_req_valid_i |-> to_shared_q[sh_req_id_i])
    else $error("shared port valid for a request routed to the integer unit");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !resp_valid_i && !sh_req_valid_i)
    else $error("output valid high during reset");

endmodule

bind offload_cc offload_cc_assert i_offload_cc_assert (
  .clk_i          ( clk_i                                                  ),
  .rst_ni         ( rst_ni                                                 ),
  .req_valid_i    ( req_valid_i                                            ),
  .req_ready_i    ( req_ready_o                                            ),
  .req_addr_i     ( req_addr_i                                             ),
  .req_id_i       ( req_id_i                                               ),
  .req_payload_i  ( {req_addr_i, req_id_i, req_op_i, req_arga_i, req_argb_i} ),
  .resp_valid_i   ( resp_valid_o                                           ),
  .resp_ready_i   ( resp_ready_i                                           ),
  .resp_payload_i ( {resp_data_o, resp_id_o, resp_error_o}                 ),
  .sh_req_valid_i ( sh_req_valid_o                                         ),
  .sh_req_id_i    ( sh_req_id_o                                            )
);

`default_nettype wire

//--- testbench/tb_offload_cc.sv
/* Testbench for offload_cc. Plays the core and the shared unit, keeps a
   scoreboard by id and compares every response with a reference model */
`default_nettype none

module tb_offload_cc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IdCount     = 2 ** $bits(offload_pkg::id_t);
  localparam int LegalReqs   = 60;
  localparam int IllegalReqs = 10;
  localparam int SharedReqs  = 20;
  localparam int MixedReqs   = 40;
  localparam int StressReqs  = 60;
  localparam int TotalReqs   = LegalReqs + IllegalReqs + SharedReqs + MixedReqs + StressReqs;
  localparam int CycleLimit  = 40 * TotalReqs + 200;
  localparam int ModeLegal   = 0;
  localparam int ModeIllegal = 1;
  localparam int ModeShared  = 2;
  localparam int ModeMixed   = 3;

  logic               clk_i, rst_ni;
  logic               req_valid_i, req_ready_o;
  offload_pkg::addr_t req_addr_i;
  offload_pkg::id_t   req_id_i, resp_id_o, sh_req_id_o, sh_resp_id_i;
  offload_pkg::op_t   req_op_i, sh_req_op_o;
  offload_pkg::data_t req_arga_i, req_argb_i, resp_data_o, sh_req_arga_o, sh_req_argb_o;
  offload_pkg::data_t sh_resp_data_i;
  logic               resp_valid_o, resp_ready_i, resp_error_o;
  logic               sh_req_valid_o, sh_req_ready_i;
  logic               sh_resp_valid_i, sh_resp_ready_o, sh_resp_error_i;

  offload_cc uut (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_addr_i, .req_id_i, .req_op_i, .req_arga_i, .req_argb_i,
    .resp_valid_o, .resp_ready_i, .resp_data_o, .resp_id_o, .resp_error_o,
    .sh_req_valid_o, .sh_req_ready_i, .sh_req_id_o, .sh_req_op_o, .sh_req_arga_o,
    .sh_req_argb_o, .sh_resp_valid_i, .sh_resp_ready_o, .sh_resp_data_i, .sh_resp_id_i,
    .sh_resp_error_i
  );

  // --------------------
  // Scoreboard
  // --------------------
  logic               in_flight [IdCount];
  string              exp_test  [IdCount];
  offload_pkg::op_t   exp_op    [IdCount];
  offload_pkg::data_t exp_a     [IdCount];
  offload_pkg::data_t exp_b     [IdCount];
  offload_pkg::data_t exp_data  [IdCount];
  logic               exp_err   [IdCount];
  offload_pkg::id_t   sh_order  [$];
  // Shared unit model answering in order
  offload_pkg::id_t   pend_id   [$];
  offload_pkg::data_t pend_data [$];
  int                 pend_due  [$];

  int   err_value, err_flag, err_other;
  int   req_count, resp_count, in_flight_cnt, cycle_count;
  logic backpressure;

  task automatic check_data(input string name, input offload_pkg::data_t exp,
                            input offload_pkg::data_t act);
    if (act !== exp) begin
      err_value++;
      $display("Error %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input offload_pkg::id_t exp,
                          input offload_pkg::id_t act);
    if (act !== exp) begin
      err_value++;
      $display("Error %s: id expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input offload_pkg::op_t exp,
                          input offload_pkg::op_t act);
    if (act !== exp) begin
      err_value++;
      $display("Error %s: op expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_error(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("Error %s: error flag expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Integer unit rules for add, sub, low product word, and, xor
  function automatic offload_pkg::data_t expected_int_result(input offload_pkg::op_t op,
      input offload_pkg::data_t a, input offload_pkg::data_t b, output logic err);
    err = 1'b0;
    case (op)
      offload_pkg::OpAdd: return a + b;
      offload_pkg::OpSub: return a - b;
      offload_pkg::OpMul: return a * b;
      offload_pkg::OpAnd: return a & b;
      offload_pkg::OpXor: return a ^ b;
      default: begin
        err = 1'b1;
        return '0;
      end
    endcase
  endfunction

  function automatic logic find_free_id(output offload_pkg::id_t id);
    int start;
    int idx;
    start = int'($urandom % IdCount);
    for (int k = 0; k < IdCount; k++) begin
      idx = (start + k) % IdCount;
      if (!in_flight[idx]) begin
        id = offload_pkg::id_t'(idx);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Called just after a falling edge
  task automatic send_request(input offload_pkg::addr_t addr, input offload_pkg::id_t id,
      input offload_pkg::op_t op, input offload_pkg::data_t a, input offload_pkg::data_t b);
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_id_i    = id;
    req_op_i    = op;
    req_arga_i  = a;
    req_argb_i  = b;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic issue_batch(input string name, input int count, input int mode);
    offload_pkg::id_t   id;
    offload_pkg::op_t   op;
    offload_pkg::data_t a, b;
    logic [31:0]        raw;
    logic               shared, err;
    for (int n = 0; n < count; n++) begin
      while (!find_free_id(id)) @(negedge clk_i);
      raw = $urandom;
      a   = $urandom;
      b   = $urandom;
      shared = (mode == ModeShared) || (mode == ModeMixed && raw[0]);
      case (mode)
        ModeLegal:   op = offload_pkg::op_t'(n % 5);
        ModeIllegal: op = offload_pkg::op_t'(5 + $urandom % 11);
        ModeShared:  op = offload_pkg::op_t'($urandom);
        default:     op = shared ? offload_pkg::op_t'($urandom) : offload_pkg::op_t'($urandom % 6);
      endcase
      if (shared) begin
        exp_data[id] = (a ^ b) + 1;
        exp_err[id]  = 1'b0;
        sh_order.push_back(id);
      end else begin
        exp_data[id] = expected_int_result(op, a, b, err);
        exp_err[id]  = err;
      end
      exp_test[id]  = name;
      exp_op[id]    = op;
      exp_a[id]     = a;
      exp_b[id]     = b;
      in_flight[id] = 1'b1;
      in_flight_cnt++;
      send_request({raw[31:1], shared}, id, op, a, b);
      req_count++;
    end
  endtask

  task automatic print_error_counts();
    $display("Error counts: value %0d, flag %0d, other %0d (%0d requests, %0d responses)",
             err_value, err_flag, err_other, req_count, resp_count);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  // Ready inputs change on the falling edge only
  initial begin
    forever begin
      @(negedge clk_i);
      resp_ready_i   = backpressure ? ($urandom % 3 != 0) : 1'b1;
      sh_req_ready_i = backpressure ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  // --------------------
  // Shared unit model
  // --------------------
  initial begin : shared_req_monitor
    offload_pkg::id_t exp_id;
    forever begin
      @(posedge clk_i);
      if (rst_ni && sh_req_valid_o && sh_req_ready_i) begin
        if (sh_order.size() == 0) begin
          err_other++;
          $display("A request reached the shared port although none was sent there");
        end else begin
          exp_id = sh_order.pop_front();
          check_id("shared forwarding", exp_id, sh_req_id_o);
          check_op("shared forwarding", exp_op[exp_id], sh_req_op_o);
          check_data("shared forwarding arga", exp_a[exp_id], sh_req_arga_o);
          check_data("shared forwarding argb", exp_b[exp_id], sh_req_argb_o);
        end
        pend_id.push_back(sh_req_id_o);
        pend_data.push_back((sh_req_arga_o ^ sh_req_argb_o) + 1);
        pend_due.push_back(cycle_count + 1 + int'($urandom % 5));
      end
      if (sh_resp_valid_i && sh_resp_ready_o) begin
        void'(pend_id.pop_front());
        void'(pend_data.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      if (pend_id.size() > 0 && pend_due[0] <= cycle_count) begin
        sh_resp_valid_i = 1'b1;
        sh_resp_id_i    = pend_id[0];
        sh_resp_data_i  = pend_data[0];
        sh_resp_error_i = 1'b0;
      end else begin
        sh_resp_valid_i = 1'b0;
      end
    end
  end

  // --------------------
  // Response compare
  // --------------------
  initial begin : response_monitor
    offload_pkg::id_t rid;
    forever begin
      @(posedge clk_i);
      if (rst_ni && resp_valid_o && resp_ready_i) begin
        rid = resp_id_o;
        if (in_flight[rid] !== 1'b1) begin
          err_other++;
          $display("Response with id %0d arrived while no request with that id was open", rid);
        end else begin
          check_data(exp_test[rid], exp_data[rid], resp_data_o);
          check_error(exp_test[rid], exp_err[rid], resp_error_o);
          in_flight[rid] = 1'b0;
          in_flight_cnt--;
          resp_count++;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < CycleLimit) @(posedge clk_i);
    $display("Timeout after %0d cycles with %0d responses missing", cycle_count, in_flight_cnt);
    for (int i = 0; i < IdCount; i++) begin
      if (in_flight[i] === 1'b1) begin
        $display("Id %0d was never returned", i);
      end
    end
    print_error_counts();
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    rst_ni          = 1'b1;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_id_i        = '0;
    req_op_i        = '0;
    req_arga_i      = '0;
    req_argb_i      = '0;
    resp_ready_i    = 1'b0;
    sh_req_ready_i  = 1'b0;
    sh_resp_valid_i = 1'b0;
    sh_resp_data_i  = '0;
    sh_resp_id_i    = '0;
    sh_resp_error_i = 1'b0;
    backpressure    = 1'b0;
    for (int i = 0; i < IdCount; i++) begin
      in_flight[i] = 1'b0;
    end
    void'($urandom(50));
    #1 rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("reset req_ready_o", 1'b0, req_ready_o);
    check_flag("reset resp_valid_o", 1'b0, resp_valid_o);
    check_flag("reset sh_req_valid_o", 1'b0, sh_req_valid_o);
    rst_ni = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("idle resp_valid_o", 1'b0, resp_valid_o);
      check_flag("idle sh_req_valid_o", 1'b0, sh_req_valid_o);
    end
    check_flag("idle req_ready_o", 1'b1, req_ready_o);

    issue_batch("legal ops", LegalReqs, ModeLegal);
    issue_batch("illegal ops", IllegalReqs, ModeIllegal);
    issue_batch("shared port", SharedReqs, ModeShared);
    issue_batch("mixed traffic", MixedReqs, ModeMixed);
    backpressure = 1'b1;
    issue_batch("back-pressure", StressReqs, ModeMixed);
    while (in_flight_cnt != 0) @(negedge clk_i);

    if (resp_count != req_count) begin
      err_other++;
      $display("Sent %0d requests but received %0d responses", req_count, resp_count);
    end
    if (sh_order.size() != 0) begin
      err_other++;
      $display("%0d shared requests never reached the shared port", sh_order.size());
    end
    print_error_counts();
    if (err_value + err_flag + err_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
